// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= irl_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== list.f ====
rtl/irl_pkg.sv
rtl/irl_if.sv
rtl/irl_mem.sv
rtl/irl_cfg_axil.sv
rtl/irl_lookup.sv
rtl/irl_meter.sv
rtl/irl_top.sv
tb/irl_tb.sv

// ==== rtl/irl_cfg_axil.sv ====
// AXI4-Lite configuration slave
`timescale 1ns/1ps

module irl_cfg_axil import irl_pkg::*; (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [AXI_ADDR_NBITS-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [AXI_DATA_NBITS-1:0]   wdata,
	input  logic [AXI_DATA_NBITS/8-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [AXI_ADDR_NBITS-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [AXI_DATA_NBITS-1:0]   rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready,
	irl_cfg_if.bus                      cfg
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WR_WAIT,
		ST_WR_RESP,
		ST_RD_WAIT,
		ST_RD_RESP
	} state_e;

	state_e     state;
	logic       in_map;
	logic [1:0] resp;

	assign in_map = is_profile_addr(cfg.addr) || is_flow_addr(cfg.addr);
	assign resp   = in_map ? AXI_RESP_OKAY : AXI_RESP_SLVERR;

	// one access at a time, writes win over reads.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			awready <= 1'b0;
			wready  <= 1'b0;
			arready <= 1'b0;
			bvalid  <= 1'b0;
			rvalid  <= 1'b0;
			cfg.wr  <= 1'b0;
			cfg.rd  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (awvalid && wvalid) begin
						awready <= 1'b1;
						wready  <= 1'b1;
						cfg.wr  <= 1'b1;
						state   <= ST_WR_WAIT;
					end else if (arvalid) begin
						arready <= 1'b1;
						cfg.rd  <= 1'b1;
						state   <= ST_RD_WAIT;
					end
				end
				ST_WR_WAIT: begin
					awready <= 1'b0;
					wready  <= 1'b0;
					cfg.wr  <= 1'b0;
					if (cfg.ack) begin
						bvalid <= 1'b1;
						state  <= ST_WR_RESP;
					end
				end
				ST_WR_RESP: begin
					if (bready) begin
						bvalid <= 1'b0;
						state  <= ST_IDLE;
					end
				end
				ST_RD_WAIT: begin
					arready <= 1'b0;
					cfg.rd  <= 1'b0;
					if (cfg.ack) begin
						rvalid <= 1'b1;
						state  <= ST_RD_RESP;
					end
				end
				ST_RD_RESP: begin
					if (rready) begin
						rvalid <= 1'b0;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// byte lanes without a strobe are written as zero.
	always_ff @(posedge clk) begin
		if (state == ST_IDLE) begin
			if (awvalid && wvalid) begin
				cfg.addr <= awaddr;
				for (int i = 0; i < AXI_DATA_NBITS / 8; i++)
					cfg.wdata[8*i +: 8] <= wstrb[i] ? wdata[8*i +: 8] : 8'h00;
			end else if (arvalid) begin
				cfg.addr <= araddr;
			end
		end
		if (state == ST_WR_WAIT && cfg.ack)
			bresp <= resp;
		if (state == ST_RD_WAIT && cfg.ack) begin
			rdata <= cfg.rdata;
			rresp <= resp;
		end
	end

	// a write response needs the address and data handshake two edges earlier.
	a_bvalid_after_write: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(bvalid) |-> $past(awvalid && awready && wvalid && wready, 2));

	a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp));

	a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== rtl/irl_if.sv ====
// Rate limiter internal ports
`timescale 1ns/1ps

// bucket and profile lookup, answered one cycle after rd.
interface irl_lookup_if import irl_pkg::*; ();
	logic                  rd;
	logic [FLOW_NBITS-1:0] flow;
	logic                  ack;
	bucket_t               bucket;
	profile_t              profile;
	logic                  fresh;
	logic                  configured;

	modport lookup (
		output rd, flow,
		input  ack, bucket, profile, fresh, configured
	);
	modport mem (
		input  rd, flow,
		output ack, bucket, profile, fresh, configured
	);
endinterface

// configuration access into the tables.
interface irl_cfg_if import irl_pkg::*; ();
	logic                      wr;
	logic                      rd;
	logic [AXI_ADDR_NBITS-1:0] addr;
	logic [AXI_DATA_NBITS-1:0] wdata;
	logic                      ack;
	logic [AXI_DATA_NBITS-1:0] rdata;

	modport bus (output wr, rd, addr, wdata, input ack, rdata);
	modport mem (input wr, rd, addr, wdata, output ack, rdata);
endinterface

// ==== rtl/irl_lookup.sv ====
// Rate limiter lookup stage
`timescale 1ns/1ps

module irl_lookup import irl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pkt_valid,
	input  logic [FLOW_NBITS-1:0] pkt_flow,
	input  logic [LEN_NBITS-1:0]  pkt_len,
	input  logic [TIME_NBITS-1:0] pkt_time,
	irl_lookup_if.lookup          lk,
	output pkt_t                  pkt_out,
	output logic                  pkt_out_valid
);

	pkt_t pkt_q;
	logic valid_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q       <= 1'b0;
			pkt_out_valid <= 1'b0;
		end else begin
			valid_q       <= pkt_valid;
			pkt_out_valid <= valid_q;
		end
	end

	// packet payload, no reset.
	always_ff @(posedge clk) begin
		pkt_q.flow   <= pkt_flow;
		pkt_q.len    <= pkt_len;
		pkt_q.tstamp <= pkt_time;
		pkt_out      <= pkt_q;
	end

	// read issued in the cycle after capture.
	// the memory answers on the same edge that moves the packet on.
	assign lk.rd   = valid_q;
	assign lk.flow = pkt_q.flow;

endmodule

// ==== rtl/irl_mem.sv ====
// Rate limiter tables and bucket memory
`timescale 1ns/1ps

module irl_mem import irl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	irl_lookup_if.mem             lk,
	irl_cfg_if.mem                cfg,
	input  logic                  bkt_wr,
	input  logic [FLOW_NBITS-1:0] bkt_flow,
	input  bucket_t               bkt_state
);

	profile_t                 prof_tab [NUM_PROFILES];
	logic [PROFILE_NBITS-1:0] flow_prof [NUM_FLOWS];
	bucket_t                  bkt_ram [NUM_FLOWS];
	logic [NUM_FLOWS-1:0]     configured;
	logic [NUM_FLOWS-1:0]     fresh;
	logic [NUM_FLOWS-1:0]     fresh_nxt;

	logic                     prof_hit;
	logic                     flow_hit;
	logic [PROFILE_NBITS-1:0] cfg_prof;
	logic [FLOW_NBITS-1:0]    cfg_flow;
	logic                     flow_cfg_wr;

	assign prof_hit    = is_profile_addr(cfg.addr);
	assign flow_hit    = is_flow_addr(cfg.addr);
	assign cfg_prof    = cfg.addr[3 +: PROFILE_NBITS];
	assign cfg_flow    = cfg.addr[2 +: FLOW_NBITS];
	assign flow_cfg_wr = cfg.wr && flow_hit;

	// a table write in the same cycle as a bucket write keeps the flow fresh.
	always_comb begin
		fresh_nxt = fresh;
		if (bkt_wr)
			fresh_nxt[bkt_flow] = 1'b0;
		if (flow_cfg_wr)
			fresh_nxt[cfg_flow] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			configured    <= '0;
			fresh         <= '0;
			cfg.ack       <= 1'b0;
			lk.ack        <= 1'b0;
			lk.fresh      <= 1'b0;
			lk.configured <= 1'b0;
		end else begin
			fresh   <= fresh_nxt;
			cfg.ack <= cfg.rd || cfg.wr;
			lk.ack  <= lk.rd;
			if (flow_cfg_wr)
				configured[cfg_flow] <= 1'b1;
			// fresh is read through the pending update.
			if (lk.rd) begin
				lk.fresh      <= fresh_nxt[lk.flow];
				lk.configured <= configured[lk.flow];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cfg.wr && prof_hit) begin
			if (cfg.addr[2])
				prof_tab[cfg_prof].excess <= cfg.wdata;
			else
				prof_tab[cfg_prof].committed <= cfg.wdata;
		end
		if (flow_cfg_wr)
			flow_prof[cfg_flow] <= cfg.wdata[PROFILE_NBITS-1:0];
		if (bkt_wr)
			bkt_ram[bkt_flow] <= bkt_state;
	end

	// lookup read, bypassing the bucket write landing on the same edge.
	always_ff @(posedge clk) begin
		if (lk.rd) begin
			lk.bucket  <= (bkt_wr && bkt_flow == lk.flow) ? bkt_state : bkt_ram[lk.flow];
			lk.profile <= prof_tab[flow_prof[lk.flow]];
		end
	end

	// configuration readback.
	always_ff @(posedge clk) begin
		if (cfg.rd) begin
			if (prof_hit)
				cfg.rdata <= cfg.addr[2] ? prof_tab[cfg_prof].excess : prof_tab[cfg_prof].committed;
			else if (flow_hit)
				cfg.rdata <= AXI_DATA_NBITS'(flow_prof[cfg_flow]);
			else
				cfg.rdata <= '0;
		end
	end

endmodule

// ==== rtl/irl_meter.sv ====
// Rate limiter meter stage
`timescale 1ns/1ps

module irl_meter import irl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	irl_lookup_if.lookup          lk,
	input  pkt_t                  pkt_in,
	input  logic                  pkt_in_valid,
	output logic                  bkt_wr,
	output logic [FLOW_NBITS-1:0] bkt_flow,
	output bucket_t               bkt_state,
	output logic                  result_valid,
	output logic [FLOW_NBITS-1:0] result_flow,
	output color_e                result_color
);

	logic                   go;
	logic                   fwd;
	logic                   fresh;
	bucket_t                cur;
	bucket_t                nxt;
	logic [TIME_NBITS-1:0]  elapsed;
	logic [TOKEN_NBITS-1:0] len_tok;
	color_e                 color;

	function automatic logic [TOKEN_NBITS-1:0] refill(
		input logic [TOKEN_NBITS-1:0] tok,
		input rate_word_t             rw,
		input logic [TIME_NBITS-1:0]  dt
	);
		logic [FILL_NBITS-1:0] sum;
		sum = FILL_NBITS'(tok) + FILL_NBITS'(rw.rate) * FILL_NBITS'(dt);
		if (sum > FILL_NBITS'(rw.burst))
			return rw.burst;
		return sum[TOKEN_NBITS-1:0];
	endfunction

	assign go = pkt_in_valid && lk.ack;

	// the previous packet's write is not yet in the RAM, so use it directly.
	assign fwd   = bkt_wr && bkt_flow == pkt_in.flow;
	assign cur   = fwd ? bkt_state : lk.bucket;
	assign fresh = lk.fresh && !fwd;

	always_comb begin
		elapsed = pkt_in.tstamp - cur.last_time;
		len_tok = TOKEN_NBITS'(pkt_in.len);
		if (fresh) begin
			nxt.ctok = lk.profile.committed.burst;
			nxt.etok = lk.profile.excess.burst;
		end else begin
			nxt.ctok = refill(cur.ctok, lk.profile.committed, elapsed);
			nxt.etok = refill(cur.etok, lk.profile.excess, elapsed);
		end
		nxt.last_time = pkt_in.tstamp;
		// the bucket that pays is charged, red pays nothing.
		if (!lk.configured) begin
			color = RED;
		end else if (nxt.ctok >= len_tok) begin
			color    = GREEN;
			nxt.ctok = nxt.ctok - len_tok;
		end else if (nxt.etok >= len_tok) begin
			color    = YELLOW;
			nxt.etok = nxt.etok - len_tok;
		end else begin
			color = RED;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			bkt_wr       <= 1'b0;
		end else begin
			result_valid <= go;
			bkt_wr       <= go && lk.configured;
		end
	end

	always_ff @(posedge clk) begin
		result_flow  <= pkt_in.flow;
		result_color <= color;
		bkt_flow     <= pkt_in.flow;
		bkt_state    <= nxt;
	end

	a_tokens_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
		bkt_wr |-> bkt_state.ctok <= $past(lk.profile.committed.burst)
			&& bkt_state.etok <= $past(lk.profile.excess.burst));

endmodule

// ==== rtl/irl_pkg.sv ====
// Ingress rate limiter definitions
package irl_pkg;

	localparam int FLOW_NBITS     = 4;
	localparam int NUM_FLOWS      = 1 << FLOW_NBITS;
	localparam int PROFILE_NBITS  = 2;
	localparam int NUM_PROFILES   = 1 << PROFILE_NBITS;
	localparam int TOKEN_NBITS    = 16;
	localparam int RATE_NBITS     = 12;
	localparam int TIME_NBITS     = 16;
	localparam int LEN_NBITS      = 14;
	localparam int FILL_NBITS     = RATE_NBITS + TIME_NBITS + 1;
	localparam int AXI_ADDR_NBITS = 8;
	localparam int AXI_DATA_NBITS = 32;

	// two words per profile, one word per flow.
	localparam logic [AXI_ADDR_NBITS-1:0] PROFILE_BASE = 8'h00;
	localparam logic [AXI_ADDR_NBITS-1:0] FLOW_BASE    = 8'h40;
	localparam int PROFILE_SPAN_NBITS = PROFILE_NBITS + 3;
	localparam int FLOW_SPAN_NBITS    = FLOW_NBITS + 2;

	localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

	typedef enum logic [1:0] {
		GREEN  = 2'd0,
		YELLOW = 2'd1,
		RED    = 2'd2
	} color_e;

	// bus word layout is {reserved, rate, burst}.
	typedef struct packed {
		logic [AXI_DATA_NBITS-RATE_NBITS-TOKEN_NBITS-1:0] rsvd;
		logic [RATE_NBITS-1:0]                            rate;
		logic [TOKEN_NBITS-1:0]                           burst;
	} rate_word_t;

	typedef struct packed {
		rate_word_t committed;
		rate_word_t excess;
	} profile_t;

	typedef struct packed {
		logic [TOKEN_NBITS-1:0] ctok;
		logic [TOKEN_NBITS-1:0] etok;
		logic [TIME_NBITS-1:0]  last_time;
	} bucket_t;

	typedef struct packed {
		logic [FLOW_NBITS-1:0] flow;
		logic [LEN_NBITS-1:0]  len;
		logic [TIME_NBITS-1:0] tstamp;
	} pkt_t;

	function automatic logic is_profile_addr(input logic [AXI_ADDR_NBITS-1:0] a);
		return (a >> PROFILE_SPAN_NBITS) == (PROFILE_BASE >> PROFILE_SPAN_NBITS);
	endfunction

	function automatic logic is_flow_addr(input logic [AXI_ADDR_NBITS-1:0] a);
		return (a >> FLOW_SPAN_NBITS) == (FLOW_BASE >> FLOW_SPAN_NBITS);
	endfunction

endpackage

// ==== rtl/irl_top.sv ====
// Ingress rate limiter top level
`timescale 1ns/1ps

module irl_top import irl_pkg::*; (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        pkt_valid,
	input  logic [FLOW_NBITS-1:0]       pkt_flow,
	input  logic [LEN_NBITS-1:0]        pkt_len,
	input  logic [TIME_NBITS-1:0]       pkt_time,
	output logic                        result_valid,
	output logic [FLOW_NBITS-1:0]       result_flow,
	output color_e                      result_color,
	input  logic [AXI_ADDR_NBITS-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [AXI_DATA_NBITS-1:0]   wdata,
	input  logic [AXI_DATA_NBITS/8-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [AXI_ADDR_NBITS-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [AXI_DATA_NBITS-1:0]   rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready
);

	pkt_t                  mid_pkt;
	logic                  mid_valid;
	logic                  bkt_wr;
	logic [FLOW_NBITS-1:0] bkt_flow;
	bucket_t               bkt_state;

	irl_lookup_if lk_if ();
	irl_cfg_if    cfg_if ();

	irl_cfg_axil u_cfg_axil (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.cfg(cfg_if.bus)
	);

	irl_lookup u_lookup (
		.clk(clk), .rst_n(rst_n),
		.pkt_valid(pkt_valid), .pkt_flow(pkt_flow), .pkt_len(pkt_len), .pkt_time(pkt_time),
		.lk(lk_if.lookup),
		.pkt_out(mid_pkt), .pkt_out_valid(mid_valid)
	);

	irl_meter u_meter (
		.clk(clk), .rst_n(rst_n),
		.lk(lk_if.lookup),
		.pkt_in(mid_pkt), .pkt_in_valid(mid_valid),
		.bkt_wr(bkt_wr), .bkt_flow(bkt_flow), .bkt_state(bkt_state),
		.result_valid(result_valid), .result_flow(result_flow), .result_color(result_color)
	);

	irl_mem u_mem (
		.clk(clk), .rst_n(rst_n),
		.lk(lk_if.mem),
		.cfg(cfg_if.mem),
		.bkt_wr(bkt_wr), .bkt_flow(bkt_flow), .bkt_state(bkt_state)
	);

endmodule

// ==== tb/irl_tb.sv ====
// Rate limiter testbench
`timescale 1ns/1ps

module irl_tb import irl_pkg::*; ();

	// about 30 AXI accesses of about 8 cycles and 320 packets, with wide margin.
	localparam int TIMEOUT_CYCLES = 4000;

	logic                        clk;
	logic                        rst_n;
	logic                        pkt_valid;
	logic [FLOW_NBITS-1:0]       pkt_flow;
	logic [LEN_NBITS-1:0]        pkt_len;
	logic [TIME_NBITS-1:0]       pkt_time;
	logic                        result_valid;
	logic [FLOW_NBITS-1:0]       result_flow;
	color_e                      result_color;
	logic [AXI_ADDR_NBITS-1:0]   awaddr;
	logic                        awvalid;
	logic                        awready;
	logic [AXI_DATA_NBITS-1:0]   wdata;
	logic [AXI_DATA_NBITS/8-1:0] wstrb;
	logic                        wvalid;
	logic                        wready;
	logic [1:0]                  bresp;
	logic                        bvalid;
	logic                        bready;
	logic [AXI_ADDR_NBITS-1:0]   araddr;
	logic                        arvalid;
	logic                        arready;
	logic [AXI_DATA_NBITS-1:0]   rdata;
	logic [1:0]                  rresp;
	logic                        rvalid;
	logic                        rready;

	// model of the tables and the buckets.
	bit     m_cfg [NUM_FLOWS];
	bit     m_fresh [NUM_FLOWS];
	int     m_prof [NUM_FLOWS];
	int     m_ctok [NUM_FLOWS];
	int     m_etok [NUM_FLOWS];
	int     m_last [NUM_FLOWS];
	int     p_crate [NUM_PROFILES];
	int     p_cburst [NUM_PROFILES];
	int     p_erate [NUM_PROFILES];
	int     p_eburst [NUM_PROFILES];

	int     exp_flow_q [$];
	color_e exp_color_q [$];
	int     exp_cyc_q [$];
	int     neg_cnt = 0;
	integer seed = 73706;
	string  test_name = "reset";

	irl_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_equal(input string what, input int expected, input int actual);
		if (expected !== actual) begin
			$display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", test_name, what,
				expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// refill by rate times elapsed ticks, clamp to burst, then charge the paying bucket.
	function automatic color_e ref_meter(input int f, input int len, input int t);
		int     p;
		int     dt;
		int     c;
		int     e;
		color_e col;
		if (!m_cfg[f])
			return RED;
		p = m_prof[f];
		if (m_fresh[f]) begin
			c = p_cburst[p];
			e = p_eburst[p];
		end else begin
			dt = (t - m_last[f]) & 'hFFFF;
			c = m_ctok[f] + p_crate[p] * dt;
			e = m_etok[f] + p_erate[p] * dt;
			if (c > p_cburst[p])
				c = p_cburst[p];
			if (e > p_eburst[p])
				e = p_eburst[p];
		end
		if (len <= c) begin
			col = GREEN;
			c = c - len;
		end else if (len <= e) begin
			col = YELLOW;
			e = e - len;
		end else begin
			col = RED;
		end
		m_ctok[f]  = c;
		m_etok[f]  = e;
		m_last[f]  = t;
		m_fresh[f] = 1'b0;
		return col;
	endfunction

	function automatic int rate_word(input int rate, input int burst);
		return {4'h0, RATE_NBITS'(rate), TOKEN_NBITS'(burst)};
	endfunction

	task automatic axil_write(input int addr, input int data, output int resp);
		@(posedge clk);
		awaddr  <= AXI_ADDR_NBITS'(addr);
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		do @(negedge clk); while (!(awready && wready));
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(negedge clk); while (!bvalid);
		resp = int'(bresp);
		// response is held for a cycle before bready.
		@(posedge clk);
		bready <= 1'b1;
		do @(negedge clk); while (bvalid);
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axil_read(input int addr, output int data, output int resp);
		@(posedge clk);
		araddr  <= AXI_ADDR_NBITS'(addr);
		arvalid <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		do @(negedge clk); while (!rvalid);
		data = int'(rdata);
		resp = int'(rresp);
		@(posedge clk);
		rready <= 1'b1;
		do @(negedge clk); while (rvalid);
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic read_check(input int addr, input int expected);
		int data;
		int resp;
		axil_read(addr, data, resp);
		check_equal("rresp", int'(AXI_RESP_OKAY), resp);
		check_equal("rdata", expected, data);
	endtask

	task automatic set_profile(input int p, input int cr, input int cb, input int er,
		input int eb);
		int resp;
		axil_write(int'(PROFILE_BASE) + p * 8, rate_word(cr, cb), resp);
		check_equal("bresp", int'(AXI_RESP_OKAY), resp);
		axil_write(int'(PROFILE_BASE) + p * 8 + 4, rate_word(er, eb), resp);
		check_equal("bresp", int'(AXI_RESP_OKAY), resp);
		p_crate[p]  = cr;
		p_cburst[p] = cb;
		p_erate[p]  = er;
		p_eburst[p] = eb;
	endtask

	// a flow entry write marks the flow configured and fresh.
	task automatic set_flow(input int f, input int p);
		int resp;
		axil_write(int'(FLOW_BASE) + f * 4, p, resp);
		check_equal("bresp", int'(AXI_RESP_OKAY), resp);
		m_prof[f]  = p;
		m_cfg[f]   = 1'b1;
		m_fresh[f] = 1'b1;
	endtask

	// the result is due four negedges after the driving edge.
	task automatic send_pkt(input int f, input int len, input int t);
		@(posedge clk);
		pkt_valid <= 1'b1;
		pkt_flow  <= FLOW_NBITS'(f);
		pkt_len   <= LEN_NBITS'(len);
		pkt_time  <= TIME_NBITS'(t);
		exp_flow_q.push_back(f);
		exp_color_q.push_back(ref_meter(f, len, t));
		exp_cyc_q.push_back(neg_cnt + 4);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			pkt_valid <= 1'b0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (exp_color_q.size() != 0)
			@(negedge clk);
		idle(2);
	endtask

	// compare process and cycle watchdog.
	always @(negedge clk) begin
		neg_cnt = neg_cnt + 1;
		if (neg_cnt > TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end else if (rst_n && result_valid) begin
			if (exp_color_q.size() == 0) begin
				$display("Error: a result came out with no packet outstanding");
				$display("SIMULATION FAILED");
				$fatal(1, "unexpected result");
			end else begin
				check_equal("latency", exp_cyc_q.pop_front(), neg_cnt);
				check_equal("flow", exp_flow_q.pop_front(), int'(result_flow));
				check_equal("color", int'(exp_color_q.pop_front()), int'(result_color));
			end
		end
	end

	initial begin
		int data;
		int resp;
		int t;
		int f;
		int len;
		rst_n     = 1'b0;
		pkt_valid = 1'b0;
		pkt_flow  = '0;
		pkt_len   = '0;
		pkt_time  = '0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '1;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		idle(2);

		test_name = "config readback";
		set_profile(0, 3, 800, 2, 1200);
		set_profile(1, 10, 1000, 5, 500);
		set_profile(2, 6, 400, 1, 300);
		set_profile(3, 12, 2000, 4, 60000);
		set_flow(1, 0);
		set_flow(2, 1);
		set_flow(5, 2);
		set_flow(9, 3);
		for (int p = 0; p < NUM_PROFILES; p++) begin
			read_check(p * 8, rate_word(p_crate[p], p_cburst[p]));
			read_check(p * 8 + 4, rate_word(p_erate[p], p_eburst[p]));
		end
		read_check(int'(FLOW_BASE) + 4, 0);
		read_check(int'(FLOW_BASE) + 8, 1);
		read_check(int'(FLOW_BASE) + 20, 2);
		read_check(int'(FLOW_BASE) + 36, 3);
		axil_write('h80, 'h1234, resp);
		check_equal("bresp", int'(AXI_RESP_SLVERR), resp);
		axil_read('h20, data, resp);
		check_equal("rresp", int'(AXI_RESP_SLVERR), resp);

		test_name = "unconfigured flow";
		send_pkt(15, 64, 50);
		drain();

		test_name = "burst drain";
		for (int i = 0; i < 6; i++)
			send_pkt(2, 300, 100);
		send_pkt(2, 100, 100);
		drain();

		test_name = "refill";
		send_pkt(2, 250, 110);
		idle(3);
		send_pkt(2, 400, 150);
		send_pkt(2, 900, 5000);
		// only a clamped committed bucket leaves too little for this one.
		send_pkt(2, 950, 5000);
		idle(1);
		send_pkt(2, 700, 65530);
		send_pkt(2, 500, 20);
		drain();

		test_name = "random traffic";
		t = 1000;
		for (int i = 0; i < 300; i++) begin
			f   = 1 + 4 * (($random(seed) & 32'h7fffffff) % 3);
			len = $random(seed) & 'hff;
			t   = (t + ($random(seed) & 'hf)) & 'hFFFF;
			send_pkt(f, len, t);
		end
		drain();

		test_name = "flow rewrite";
		set_flow(5, 2);
		send_pkt(5, 400, t);
		send_pkt(5, 10, t);
		drain();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
